// ==== flist.f ====
src/exPkg.sv
src/operandForward.sv
src/aluCore.sv
src/mulControl.sv
src/mulCycleCounter.sv
src/mulDatapath.sv
src/hiloRegs.sv
src/executeStage.sv
verif/executeStage_assertions.sv
verif/executeStageTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= executeStageTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/executeStageTb.sv ====
`default_nettype none

module executeStageTb;

    import exPkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Run sizing
    ////////////////////////////////////////////////////////////////////////////

    localparam int CLK_PERIOD = 20;
    localparam int ALU_OPS    = 18;
    localparam int ALU_PAIRS  = 20;
    // Operand pairs, each run as MULT and MULTU
    localparam int MUL_PAIRS  = 7;
    // Busy cycles, readback and slack for one multiply
    localparam int MUL_BUDGET = MUL_CYCLES + 8;
    localparam int BUDGET_CYCLES = ALU_OPS * ALU_PAIRS + 32
                                 + (2 * MUL_PAIRS + 2) * MUL_BUDGET + 100;

    logic        clk = 1'b0;
    logic        reset;
    exCtrl_t     ctrl;
    exOperands_t operands;
    fwdCtrl_t    fwd;
    logic [31:0] memAluOut;
    logic [31:0] wbValue;
    logic [31:0] result;
    logic [31:0] forwardRtData;
    logic [4:0]  destReg;
    logic        resultNotOk;

    // Reference HI/LO
    logic [31:0] modelHi;
    logic [31:0] modelLo;
    logic [31:0] rngState;
    int          errorCount;

    always #(CLK_PERIOD / 2) clk = ~clk;

    executeStage dut_i (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (ctrl),
        .operands      (operands),
        .fwd           (fwd),
        .memAluOut     (memAluOut),
        .wbValue       (wbValue),
        .result        (result),
        .forwardRtData (forwardRtData),
        .destReg       (destReg),
        .resultNotOk   (resultNotOk)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers and reference model
    ////////////////////////////////////////////////////////////////////////////

    // 32-bit xorshift
    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [4:0] randomField();
        logic [31:0] r;
        r = nextRandom();
        return r[4:0];
    endfunction

    function automatic exCtrl_t makeCtrl(input aluOp_t op, input logic aluSrc,
                                         input logic regDst, input logic shiftImm);
        exCtrl_t c;
        c.aluOp    = op;
        c.aluSrc   = aluSrc;
        c.regDst   = regDst;
        c.shiftImm = shiftImm;
        return c;
    endfunction

    function automatic exOperands_t makeOperands(input logic [31:0] rs, input logic [31:0] rt,
                                                 input logic [31:0] imm, input logic [4:0] rtNum,
                                                 input logic [4:0] rdNum, input logic [4:0] shamt);
        exOperands_t o;
        o.rsData    = rs;
        o.rtData    = rt;
        o.immediate = imm;
        o.rt        = rtNum;
        o.rd        = rdNum;
        o.shamt     = shamt;
        return o;
    endfunction

    function automatic fwdCtrl_t makeFwd(input fwdSel_t rsSel, input fwdSel_t rtSel);
        fwdCtrl_t f;
        f.rsSel = rsSel;
        f.rtSel = rtSel;
        return f;
    endfunction

    // Expected result for every non-multiply opcode
    function automatic logic [31:0] modelAlu(input aluOp_t op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] fill;
        sh   = a[4:0];
        // Sign bits that an arithmetic shift pulls in from the left
        fill = b[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0;
        case (op)
            OP_ADD, OP_ADDU: return a + b;
            OP_SUB, OP_SUBU: return a - b;
            OP_AND:          return a & b;
            OP_OR:           return a | b;
            OP_XOR:          return a ^ b;
            OP_NOR:          return ~(a | b);
            // Flipping the sign bit maps signed order onto unsigned order
            OP_SLT:          return {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            OP_SLTU:         return {31'd0, a < b};
            OP_SLL:          return b << sh;
            OP_SRL:          return b >> sh;
            OP_SRA:          return (b >> sh) | fill;
            OP_LUI:          return b << 16;
            OP_MFHI:         return modelHi;
            OP_MFLO:         return modelLo;
            default:         return 32'd0;
        endcase
    endfunction

    // Extended operands, product modulo 2^64 is exact
    function automatic logic [63:0] modelProduct(input aluOp_t op, input logic [31:0] a,
                                                 input logic [31:0] b);
        logic [63:0] wideA;
        logic [63:0] wideB;
        if (op == OP_MULT) begin
            wideA = {{32{a[31]}}, a};
            wideB = {{32{b[31]}}, b};
        end else begin
            wideA = {32'd0, a};
            wideB = {32'd0, b};
        end
        return wideA * wideB;
    endfunction

    // Drive on the rising edge, outputs settled by the falling edge
    task automatic applyInputs(input exCtrl_t c, input exOperands_t o, input fwdCtrl_t f,
                               input logic [31:0] mem, input logic [31:0] wb);
        @(posedge clk);
        ctrl      <= c;
        operands  <= o;
        fwd       <= f;
        memAluOut <= mem;
        wbValue   <= wb;
        @(negedge clk);
    endtask

    // Register-file operands, no forwarding, rd destination
    task automatic applyRegOp(input aluOp_t op, input logic [31:0] rs, input logic [31:0] rt);
        applyInputs(makeCtrl(op, 1'b0, 1'b1, 1'b0),
                    makeOperands(rs, rt, nextRandom(), randomField(), randomField(),
                                 randomField()),
                    makeFwd(FWD_REG, FWD_REG), nextRandom(), nextRandom());
    endtask

    // Two reset cycles
    task automatic applyReset();
        if (!reset) begin
            @(posedge clk);
            reset <= 1'b1;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            errorCount++;
            $display("Mismatch in %s: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic testAluOps();
        aluOp_t      ops [ALU_OPS];
        logic [31:0] a;
        logic [31:0] b;
        // Move-to ahead of move-from so reads see fresh values
        ops = '{OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLT,
                OP_SLTU, OP_SLL, OP_SRL, OP_SRA, OP_LUI, OP_MTHI, OP_MTLO, OP_MFHI, OP_MFLO};
        foreach (ops[i]) begin
            for (int n = 0; n < ALU_PAIRS; n++) begin
                a = nextRandom();
                b = nextRandom();
                applyRegOp(ops[i], a, b);
                checkValue($sformatf("aluOps %s", ops[i].name()), modelAlu(ops[i], a, b),
                           result);
                // HI/LO take rs on the following edge
                if (ops[i] == OP_MTHI) begin
                    modelHi = a;
                end
                if (ops[i] == OP_MTLO) begin
                    modelLo = a;
                end
            end
        end
    endtask

    task automatic testForwarding();
        fwdSel_t     rsSel;
        fwdSel_t     rtSel;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] mem;
        logic [31:0] wb;
        logic [31:0] expA;
        logic [31:0] expB;
        string       name;
        for (int rs = 0; rs < 3; rs++) begin
            for (int rt = 0; rt < 3; rt++) begin
                rsSel = fwdSel_t'(rs);
                rtSel = fwdSel_t'(rt);
                a     = nextRandom();
                b     = nextRandom();
                mem   = nextRandom();
                wb    = nextRandom();
                expA  = (rsSel == FWD_MEM) ? mem : ((rsSel == FWD_WB) ? wb : a);
                expB  = (rtSel == FWD_MEM) ? mem : ((rtSel == FWD_WB) ? wb : b);
                applyInputs(makeCtrl(OP_ADD, 1'b0, 1'b1, 1'b0),
                            makeOperands(a, b, nextRandom(), randomField(), randomField(),
                                         randomField()),
                            makeFwd(rsSel, rtSel), mem, wb);
                name = $sformatf("forwarding %s/%s", rsSel.name(), rtSel.name());
                checkValue(name, expA + expB, result);
                checkValue({name, " store data"}, expB, forwardRtData);
            end
        end
        // WB forward wins over a shamt that differs from it
        b  = nextRandom();
        wb = nextRandom();
        applyInputs(makeCtrl(OP_SLL, 1'b0, 1'b1, 1'b1),
                    makeOperands(nextRandom(), b, nextRandom(), randomField(), randomField(),
                                 ~wb[4:0]),
                    makeFwd(FWD_WB, FWD_REG), nextRandom(), wb);
        checkValue("forwarding over shamt", b << wb[4:0], result);
    endtask

    task automatic testSelects();
        aluOp_t      shiftOps [3];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [4:0]  shamt;
        logic [4:0]  rtNum;
        logic [4:0]  rdNum;
        // Immediate reaches the ALU, store data keeps rt
        for (int n = 0; n < 4; n++) begin
            a   = nextRandom();
            b   = nextRandom();
            imm = nextRandom();
            applyInputs(makeCtrl(OP_ADDU, 1'b1, 1'b0, 1'b0),
                        makeOperands(a, b, imm, randomField(), randomField(), randomField()),
                        makeFwd(FWD_REG, FWD_REG), nextRandom(), nextRandom());
            checkValue("selects immediate", a + imm, result);
            checkValue("selects store data", b, forwardRtData);
        end
        shiftOps = '{OP_SLL, OP_SRL, OP_SRA};
        foreach (shiftOps[i]) begin
            shamt  = randomField();
            // Rs low bits never equal shamt
            a      = nextRandom();
            a[4:0] = ~shamt;
            // Negative rt so SRA fill shows
            b      = nextRandom() | 32'h8000_0000;
            applyInputs(makeCtrl(shiftOps[i], 1'b0, 1'b1, 1'b1),
                        makeOperands(a, b, nextRandom(), randomField(),
                                     randomField(), shamt),
                        makeFwd(FWD_REG, FWD_REG), nextRandom(), nextRandom());
            checkValue($sformatf("selects shamt %s", shiftOps[i].name()),
                       modelAlu(shiftOps[i], {27'd0, shamt}, b), result);
        end
        rtNum = randomField();
        rdNum = ~rtNum;
        for (int sel = 0; sel < 2; sel++) begin
            applyInputs(makeCtrl(OP_OR, 1'b0, sel[0], 1'b0),
                        makeOperands(nextRandom(), nextRandom(), nextRandom(), rtNum, rdNum,
                                     randomField()),
                        makeFwd(FWD_REG, FWD_REG), nextRandom(), nextRandom());
            checkValue($sformatf("selects regDst=%0d", sel),
                       {27'd0, (sel == 1) ? rdNum : rtNum}, {27'd0, destReg});
        end
    endtask

    // One multiply, stall length, then MFHI and MFLO readback
    task automatic runMultiply(input aluOp_t op, input logic [31:0] a, input logic [31:0] b);
        logic [63:0] expProduct;
        int          busyCycles;
        string       name;
        expProduct = modelProduct(op, a, b);
        name       = $sformatf("multiply %s %h*%h", op.name(), a, b);
        applyRegOp(op, a, b);
        busyCycles = 0;
        // Inputs held while stalled, bounded in case the stall never ends
        while (resultNotOk && busyCycles <= MUL_CYCLES + 4) begin
            busyCycles++;
            @(negedge clk);
        end
        checkValue({name, " busy cycles"}, MUL_CYCLES + 1, busyCycles);
        applyRegOp(OP_MFHI, nextRandom(), nextRandom());
        checkValue({name, " hi"}, expProduct[63:32], result);
        applyRegOp(OP_MFLO, nextRandom(), nextRandom());
        checkValue({name, " lo"}, expProduct[31:0], result);
        modelHi = expProduct[63:32];
        modelLo = expProduct[31:0];
    endtask

    task automatic testMultiply();
        logic [31:0] mulA [MUL_PAIRS];
        logic [31:0] mulB [MUL_PAIRS];
        // Reset lands halfway through a multiply
        applyRegOp(OP_MULT, nextRandom(), nextRandom());
        repeat (MUL_CYCLES / 2) @(negedge clk);
        @(posedge clk);
        reset <= 1'b1;
        ctrl  <= makeCtrl(OP_ADDU, 1'b0, 1'b0, 1'b0);
        applyReset();
        modelHi = 32'd0;
        modelLo = 32'd0;
        checkValue("multiply after reset", 32'd0, {31'd0, resultNotOk});
        // Random, negative and extreme corners
        mulA = '{nextRandom(), nextRandom() | 32'h8000_0000, 32'hFFFF_FFF9, 32'h8000_0000,
                 32'h7FFF_FFFF, 32'hFFFF_FFFF, 32'd0};
        mulB = '{nextRandom(), nextRandom() | 32'h8000_0000, 32'h0000_0013, 32'h8000_0000,
                 32'h8000_0000, 32'hFFFF_FFFF, nextRandom()};
        for (int n = 0; n < MUL_PAIRS; n++) begin
            runMultiply(OP_MULT, mulA[n], mulB[n]);
            runMultiply(OP_MULTU, mulA[n], mulB[n]);
        end
    endtask

    task automatic testMoveTo();
        logic [31:0] hiValue;
        logic [31:0] loValue;
        hiValue = nextRandom();
        loValue = nextRandom();
        applyRegOp(OP_MTHI, hiValue, nextRandom());
        applyRegOp(OP_MTLO, loValue, nextRandom());
        modelHi = hiValue;
        modelLo = loValue;
        applyRegOp(OP_MFHI, nextRandom(), nextRandom());
        checkValue("moveTo hi", hiValue, result);
        applyRegOp(OP_MFLO, nextRandom(), nextRandom());
        checkValue("moveTo lo", loValue, result);
        // Multiply replaces both halves
        runMultiply(OP_MULT, nextRandom(), nextRandom());
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        errorCount = 0;
        rngState   = 32'd97504;
        modelHi    = 32'd0;
        modelLo    = 32'd0;
        reset      = 1'b1;
        ctrl       = makeCtrl(OP_ADDU, 1'b0, 1'b0, 1'b0);
        operands   = makeOperands(32'd0, 32'd0, 32'd0, 5'd0, 5'd0, 5'd0);
        fwd        = makeFwd(FWD_REG, FWD_REG);
        memAluOut  = 32'd0;
        wbValue    = 32'd0;
        applyReset();
        testAluOps();
        testForwarding();
        testSelects();
        testMultiply();
        testMoveTo();
        $display("Summary: %0d check errors, %0d assertion failures", errorCount,
                 dut_i.assertions_i.failCount);
        if (errorCount == 0 && dut_i.assertions_i.failCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * BUDGET_CYCLES);
        $display("Watchdog expired after %0d cycles, the tests did not finish", BUDGET_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/executeStage_assertions.sv ====
`default_nettype none

module executeStageAssertions (
    input wire logic clk,
    input wire logic reset,
    input wire logic mulLoad,
    input wire logic mulStep,
    input wire logic mulDone,
    input wire logic resultNotOk
);

    import exPkg::*;

    // Failures so far, picked up by the testbench summary
    int failCount = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Multiplier protocol
    ////////////////////////////////////////////////////////////////////////////

    // Load, full run, then the done cycle with the stall dropped
    loadToDone: assert property (@(posedge clk) disable iff (reset)
        mulLoad |-> ##(MUL_CYCLES + 1) (mulDone && !resultNotOk))
        else begin
            failCount++;
            $error("multiply load did not reach done %0d cycles later", MUL_CYCLES + 1);
        end

    // Pipeline stays stalled on every iteration
    stepStalls: assert property (@(posedge clk) disable iff (reset)
        mulStep |-> resultNotOk)
        else begin
            failCount++;
            $error("resultNotOk dropped while the multiplier was still iterating");
        end

    // Done lasts one cycle only
    donePulse: assert property (@(posedge clk) disable iff (reset)
        mulDone |=> !mulDone)
        else begin
            failCount++;
            $error("mulDone stayed high for more than one cycle");
        end

    loadNotDone: assert property (@(posedge clk) disable iff (reset)
        !(mulLoad && mulDone))
        else begin
            failCount++;
            $error("mulLoad and mulDone were high in the same cycle");
        end

    // Idle right out of reset
    resetIdle: assert property (@(posedge clk)
        $fell(reset) |-> !resultNotOk)
        else begin
            failCount++;
            $error("resultNotOk was high just after reset");
        end

endmodule

bind executeStage executeStageAssertions assertions_i (
    .clk         (clk),
    .reset       (reset),
    .mulLoad     (mulLoad),
    .mulStep     (mulStep),
    .mulDone     (mulDone),
    .resultNotOk (resultNotOk)
);

`default_nettype wire

// ==== src/executeStage.sv ====
`default_nettype none

module executeStage (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire exPkg::exCtrl_t     ctrl,
    input  wire exPkg::exOperands_t operands,
    input  wire exPkg::fwdCtrl_t    fwd,
    input  wire logic [31:0]        memAluOut,
    input  wire logic [31:0]        wbValue,
    output logic [31:0]             result,
    output logic [31:0]             forwardRtData,
    output logic [4:0]              destReg,
    output logic                    resultNotOk
);

    import exPkg::*;

    // Resolved ALU operands
    logic [31:0] srcA;
    logic [31:0] srcB;

    // Multiplier sequencing
    logic        mulLoad;
    logic        mulStep;
    logic        mulDone;
    logic        isSigned;
    logic        lastCycle;
    logic [63:0] product;

    hiLo_t       hiLo;

    ////////////////////////////////////////////////////////////////////////////
    // Operand path and ALU
    ////////////////////////////////////////////////////////////////////////////

    operandForward operandForward_i (
        .ctrl          (ctrl),
        .operands      (operands),
        .fwd           (fwd),
        .memAluOut     (memAluOut),
        .wbValue       (wbValue),
        .srcA          (srcA),
        .srcB          (srcB),
        .forwardRtData (forwardRtData),
        .destReg       (destReg)
    );

    aluCore aluCore_i (
        .aluOp  (ctrl.aluOp),
        .srcA   (srcA),
        .srcB   (srcB),
        .hiLo   (hiLo),
        .result (result)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Multiplier and HI/LO
    ////////////////////////////////////////////////////////////////////////////

    mulControl mulControl_i (
        .clk         (clk),
        .reset       (reset),
        .aluOp       (ctrl.aluOp),
        .lastCycle   (lastCycle),
        .mulLoad     (mulLoad),
        .mulStep     (mulStep),
        .mulDone     (mulDone),
        .isSigned    (isSigned),
        .resultNotOk (resultNotOk)
    );

    mulCycleCounter mulCycleCounter_i (
        .clk       (clk),
        .reset     (reset),
        .mulLoad   (mulLoad),
        .mulStep   (mulStep),
        .lastCycle (lastCycle)
    );

    mulDatapath mulDatapath_i (
        .clk      (clk),
        .reset    (reset),
        .mulLoad  (mulLoad),
        .mulStep  (mulStep),
        .isSigned (isSigned),
        .srcA     (srcA),
        .srcB     (srcB),
        .product  (product)
    );

    hiloRegs hiloRegs_i (
        .clk     (clk),
        .reset   (reset),
        .mulDone (mulDone),
        .product (product),
        .aluOp   (ctrl.aluOp),
        .srcA    (srcA),
        .hiLo    (hiLo)
    );

endmodule

`default_nettype wire

// ==== src/hiloRegs.sv ====
`default_nettype none

module hiloRegs (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          mulDone,
    input  wire logic [63:0]   product,
    input  wire exPkg::aluOp_t aluOp,
    input  wire logic [31:0]   srcA,
    output exPkg::hiLo_t       hiLo
);

    import exPkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            hiLo <= '0;
        end else if (mulDone) begin
            // Full product lands in one edge
            hiLo.hi <= product[63:32];
            hiLo.lo <= product[31:0];
        end else begin
            // Move-to from forwarded rs
            if (aluOp == OP_MTHI) begin
                hiLo.hi <= srcA;
            end
            if (aluOp == OP_MTLO) begin
                hiLo.lo <= srcA;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/mulDatapath.sv ====
`default_nettype none

module mulDatapath (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        mulLoad,
    input  wire logic        mulStep,
    input  wire logic        isSigned,
    input  wire logic [31:0] srcA,
    input  wire logic [31:0] srcB,
    output logic [63:0]      product
);

    // Shift registers for the running multiply
    logic [63:0] multiplicand;
    logic [31:0] multiplier;
    logic [63:0] accum;
    logic        negResult;

    // Operand magnitudes
    logic [31:0] magA;
    logic [31:0] magB;

    // Two's complement abs, unsigned ops pass through
    assign magA = (isSigned && srcA[31]) ? (~srcA + 32'd1) : srcA;
    assign magB = (isSigned && srcB[31]) ? (~srcB + 32'd1) : srcB;

    ////////////////////////////////////////////////////////////////////////////
    // Shift-add iteration
    ////////////////////////////////////////////////////////////////////////////

    // Operands held after load, caller may change inputs
    always_ff @(posedge clk) begin
        if (mulLoad) begin
            multiplicand <= {32'd0, magA};
            multiplier   <= magB;
        end else if (mulStep) begin
            multiplicand <= multiplicand << 1;
            multiplier   <= multiplier >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            accum     <= '0;
            negResult <= 1'b0;
        end else if (mulLoad) begin
            accum     <= '0;
            negResult <= isSigned && (srcA[31] ^ srcB[31]);
        end else if (mulStep && multiplier[0]) begin
            accum <= accum + multiplicand;
        end
    end

    // Sign fix on the way out
    assign product = negResult ? (~accum + 64'd1) : accum;

endmodule

`default_nettype wire

// ==== src/mulCycleCounter.sv ====
`default_nettype none

module mulCycleCounter (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic mulLoad,
    input  wire logic mulStep,
    output logic      lastCycle
);

    import exPkg::*;

    logic [MUL_COUNT_W-1:0] count;

    // Restart on each new multiply
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (mulLoad) begin
            count <= '0;
        end else if (mulStep) begin
            // Wraps back to zero after the final step
            count <= count + 1'b1;
        end
    end

    assign lastCycle = (count == MUL_COUNT_W'(MUL_CYCLES - 1));

endmodule

`default_nettype wire

// ==== src/mulControl.sv ====
`default_nettype none

module mulControl (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire exPkg::aluOp_t aluOp,
    input  wire logic          lastCycle,
    output logic               mulLoad,
    output logic               mulStep,
    output logic               mulDone,
    output logic               isSigned,
    output logic               resultNotOk
);

    import exPkg::*;

    mulState_t state;
    mulState_t nextState;
    logic      isMul;

    // Multiply decode lives only here
    assign isMul    = (aluOp == OP_MULT) || (aluOp == OP_MULTU);
    assign isSigned = (aluOp == OP_MULT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= MUL_IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            MUL_IDLE: begin
                // Start on the first cycle the opcode shows up
                if (isMul) begin
                    nextState = MUL_RUN;
                end
            end
            MUL_RUN: begin
                if (lastCycle) begin
                    nextState = MUL_DONE;
                end
            end
            // HI/LO written at end of this cycle
            MUL_DONE: nextState = MUL_IDLE;
            default:  nextState = MUL_IDLE;
        endcase
    end

    // Strobes straight from state
    assign mulLoad = (state == MUL_IDLE) && isMul;
    assign mulStep = (state == MUL_RUN);
    assign mulDone = (state == MUL_DONE);

    // Pipeline holds until the done cycle
    assign resultNotOk = isMul && (state != MUL_DONE);

endmodule

`default_nettype wire

// ==== src/aluCore.sv ====
`default_nettype none

module aluCore (
    input  wire exPkg::aluOp_t aluOp,
    input  wire logic [31:0]   srcA,
    input  wire logic [31:0]   srcB,
    input  wire exPkg::hiLo_t  hiLo,
    output logic [31:0]        result
);

    import exPkg::*;

    logic [31:0] aluResult;
    logic [4:0]  shiftAmt;

    // Shift count from low rs bits
    assign shiftAmt = srcA[4:0];

    ////////////////////////////////////////////////////////////////////////////
    // Single-cycle ALU
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (aluOp)
            // No overflow trap, plain wrap
            OP_ADD, OP_ADDU: aluResult = srcA + srcB;
            OP_SUB, OP_SUBU: aluResult = srcA - srcB;
            OP_AND:          aluResult = srcA & srcB;
            OP_OR:           aluResult = srcA | srcB;
            OP_XOR:          aluResult = srcA ^ srcB;
            OP_NOR:          aluResult = ~(srcA | srcB);
            // Set-on-less-than
            OP_SLT:          aluResult = {31'd0, $signed(srcA) < $signed(srcB)};
            OP_SLTU:         aluResult = {31'd0, srcA < srcB};
            // Shifts act on rt side
            OP_SLL:          aluResult = srcB << shiftAmt;
            OP_SRL:          aluResult = srcB >> shiftAmt;
            OP_SRA:          aluResult = $unsigned($signed(srcB) >>> shiftAmt);
            OP_LUI:          aluResult = {srcB[15:0], 16'd0};
            // Multiply and move-to produce nothing here
            default:         aluResult = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Final result select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (aluOp)
            OP_MFHI: result = hiLo.hi;
            OP_MFLO: result = hiLo.lo;
            default: result = aluResult;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/operandForward.sv ====
`default_nettype none

module operandForward (
    input  wire exPkg::exCtrl_t     ctrl,
    input  wire exPkg::exOperands_t operands,
    input  wire exPkg::fwdCtrl_t    fwd,
    input  wire logic [31:0]        memAluOut,
    input  wire logic [31:0]        wbValue,
    output logic [31:0]             srcA,
    output logic [31:0]             srcB,
    output logic [31:0]             forwardRtData,
    output logic [4:0]              destReg
);

    import exPkg::*;

    // Rs path before forwarding
    logic [31:0] rsBase;

    // Three-way operand source pick
    function automatic logic [31:0] pickSource(
        input fwdSel_t     sel,
        input logic [31:0] regValue,
        input logic [31:0] memValue,
        input logic [31:0] wbVal
    );
        case (sel)
            FWD_MEM: return memValue;
            FWD_WB:  return wbVal;
            // Unused encoding falls back to the register read
            default: return regValue;
        endcase
    endfunction

    // Shift amount replaces rs for immediate shifts
    assign rsBase = ctrl.shiftImm ? {27'd0, operands.shamt} : operands.rsData;

    // Forward mux still wins over the shift amount
    assign srcA = pickSource(fwd.rsSel, rsBase, memAluOut, wbValue);

    // Store data is always the forwarded rt
    assign forwardRtData = pickSource(fwd.rtSel, operands.rtData, memAluOut, wbValue);

    // Immediate select after forwarding
    assign srcB = ctrl.aluSrc ? operands.immediate : forwardRtData;

    // R-type writes rd, I-type writes rt
    assign destReg = ctrl.regDst ? operands.rd : operands.rt;

endmodule

`default_nettype wire

// ==== src/exPkg.sv ====
`default_nettype none

package exPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Multiplier sizing
    ////////////////////////////////////////////////////////////////////////////

    // One product bit per iteration
    localparam int MUL_CYCLES  = 32;
    // Wide enough to index every iteration
    localparam int MUL_COUNT_W = 5;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes and selects
    ////////////////////////////////////////////////////////////////////////////

    // Execute opcodes, funct-style encoding from decode
    typedef enum logic [7:0] {
        OP_SLL   = 8'h00,
        OP_SRL   = 8'h02,
        OP_SRA   = 8'h03,
        OP_LUI   = 8'h0F,
        OP_MFHI  = 8'h10,
        OP_MTHI  = 8'h11,
        OP_MFLO  = 8'h12,
        OP_MTLO  = 8'h13,
        OP_MULT  = 8'h18,
        OP_MULTU = 8'h19,
        OP_ADD   = 8'h20,
        OP_ADDU  = 8'h21,
        OP_SUB   = 8'h22,
        OP_SUBU  = 8'h23,
        OP_AND   = 8'h24,
        OP_OR    = 8'h25,
        OP_XOR   = 8'h26,
        OP_NOR   = 8'h27,
        OP_SLT   = 8'h2A,
        OP_SLTU  = 8'h2B
    } aluOp_t;

    // Operand source, picked by the hazard unit
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwdSel_t;

    // Multiplier sequencer states
    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_RUN,
        MUL_DONE
    } mulState_t;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        fwdSel_t rsSel;
        fwdSel_t rtSel;
    } fwdCtrl_t;

    typedef struct packed {
        aluOp_t aluOp;
        logic   aluSrc;
        logic   regDst;
        logic   shiftImm;
    } exCtrl_t;

    // Register reads and instruction fields from ID/EX
    typedef struct packed {
        logic [31:0] rsData;
        logic [31:0] rtData;
        logic [31:0] immediate;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
    } exOperands_t;

    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } hiLo_t;

endpackage

`default_nettype wire
